// ==== verilog/holo_pkg.sv ====
// video timing, frame-buffer window, colour and TMDS constants, TMDS control enum
`default_nettype none

package holo_pkg;

  // 1280x720 raster, 74.25 MHz style timing in pixel clocks
  localparam int H_ACTIVE = 1280;
  localparam int H_FRONT  = 110;
  localparam int H_SYNC   = 40;
  localparam int H_BACK   = 220;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  localparam int V_ACTIVE = 720;
  localparam int V_FRONT  = 5;
  localparam int V_SYNC   = 5;
  localparam int V_BACK   = 20;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // sync pulse bounds, start inclusive, end exclusive
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  // counter widths, 1650 and 750 fit
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // frame-buffer window in the top left corner
  localparam int FB_HRES = 320;
  localparam int FB_VRES = 180;

  // packed rgb565 in, 8 bits per channel out
  localparam int PIXEL_W = 16;
  localparam int COLOR_W = 8;
  localparam int TMDS_W  = 10;

  // running disparity range, signed
  localparam int TMDS_DISP_W = 6;

  // pure red, shown when no word is taken
  localparam logic [PIXEL_W-1:0] FALLBACK_PIXEL = 16'hf800;

  // control value, bit 1 vsync, bit 0 hsync
  typedef enum logic [1:0] {
    CTRL_NONE  = 2'd0,
    CTRL_HSYNC = 2'd1,
    CTRL_VSYNC = 2'd2,
    CTRL_BOTH  = 2'd3
  } tmds_ctrl_e;

  // standard blanking symbols
  localparam logic [TMDS_W-1:0] TMDS_CTRL_SYM0 = 10'b1101010100;
  localparam logic [TMDS_W-1:0] TMDS_CTRL_SYM1 = 10'b0010101011;
  localparam logic [TMDS_W-1:0] TMDS_CTRL_SYM2 = 10'b0101010100;
  localparam logic [TMDS_W-1:0] TMDS_CTRL_SYM3 = 10'b1010101011;

endpackage

`default_nettype wire

// ==== verilog/video_timing_if.sv ====
// video timing interface, pixel position, syncs and active flag with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface video_timing_if
  import holo_pkg::*;
();

  // raster position
  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  // decoded timing, same cycle as position
  logic                hsync;
  logic                vsync;
  logic                active;

  // generator side
  modport source (output hcount, vcount, hsync, vsync, active);
  // consumer side
  modport sink (input hcount, vcount, hsync, vsync, active);

endinterface

`default_nettype wire

// ==== verilog/video_timing_gen.sv ====
// 720p timing generator, pixel and line counters with sync and active-draw decode
`timescale 1ns/1ps
`default_nettype none

module video_timing_gen
  import holo_pkg::*;
(
  input  wire            clk_100_passthrough,
  input  wire            recent_reset,
  video_timing_if.source timing_o
);

  logic [HCOUNT_W-1:0] hcount_q;
  logic [VCOUNT_W-1:0] vcount_q;
  logic                line_end;
  logic                frame_end;

  // last pixel of a line, last line of a frame
  assign line_end  = (hcount_q == HCOUNT_W'(H_TOTAL - 1));
  assign frame_end = (vcount_q == VCOUNT_W'(V_TOTAL - 1));

  // one pixel per clock
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      hcount_q <= '0;
      vcount_q <= '0;
    end else if (line_end) begin
      hcount_q <= '0;
      // line wrap, step or restart frame
      if (frame_end) begin
        vcount_q <= '0;
      end else begin
        vcount_q <= vcount_q + 1'b1;
      end
    end else begin
      hcount_q <= hcount_q + 1'b1;
    end
  end

  // position straight out
  assign timing_o.hcount = hcount_q;
  assign timing_o.vcount = vcount_q;

  // syncs, positive pulses
  // counters sit at 0 in reset so syncs stay low there
  assign timing_o.hsync = (hcount_q >= HCOUNT_W'(H_SYNC_START))
                       && (hcount_q <  HCOUNT_W'(H_SYNC_END));
  assign timing_o.vsync = (vcount_q >= VCOUNT_W'(V_SYNC_START))
                       && (vcount_q <  VCOUNT_W'(V_SYNC_END));

  // visible area
  // (0,0) is visible, so reset has to hold it low
  assign timing_o.active = !recent_reset
                        && (hcount_q < HCOUNT_W'(H_ACTIVE))
                        && (vcount_q < VCOUNT_W'(V_ACTIVE));

endmodule

`default_nettype wire

// ==== verilog/fb_pixel_fetch.sv ====
// frame-buffer stream consumer, ready rule, rgb565 expansion with fallback, aligned timing
`timescale 1ns/1ps
`default_nettype none

module fb_pixel_fetch
  import holo_pkg::*;
(
  input  wire                clk_100_passthrough,
  input  wire                recent_reset,
  video_timing_if.sink       timing_i,
  input  wire                fb_tvalid_i,
  input  wire  [PIXEL_W-1:0] fb_tdata_i,
  input  wire                fb_tlast_i,
  output logic               fb_tready_o,
  output logic [COLOR_W-1:0] red_o,
  output logic [COLOR_W-1:0] green_o,
  output logic [COLOR_W-1:0] blue_o,
  output logic               active_o,
  output tmds_ctrl_e         blue_ctrl_o
);

  logic               in_window;
  logic               at_last;
  logic [PIXEL_W-1:0] pixel;

  // anywhere in the 320x180 corner, blanking columns excluded by hcount
  assign in_window = (timing_i.hcount < HCOUNT_W'(FB_HRES))
                  && (timing_i.vcount < VCOUNT_W'(FB_VRES));

  // final window pixel, only while drawing
  assign at_last = timing_i.active
                && (timing_i.hcount == HCOUNT_W'(FB_HRES - 1))
                && (timing_i.vcount == VCOUNT_W'(FB_VRES - 1));

  // a flagged last word waits for the window's end
  assign fb_tready_o = fb_tlast_i ? at_last : in_window;

  // stream word on handshake, otherwise red
  assign pixel = (fb_tvalid_i && fb_tready_o) ? fb_tdata_i : FALLBACK_PIXEL;

  // colour expansion, fields to the top of the byte
  always_ff @(posedge clk_100_passthrough) begin
    red_o   <= {pixel[15:11], 3'b000};
    green_o <= {pixel[10:5], 2'b00};
    blue_o  <= {pixel[4:0], 3'b000};
  end

  // timing delayed by the same cycle as the colour
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      active_o    <= 1'b0;
      blue_ctrl_o <= CTRL_NONE;
    end else begin
      active_o    <= timing_i.active;
      // blue lane carries {vsync, hsync}
      blue_ctrl_o <= tmds_ctrl_e'({timing_i.vsync, timing_i.hsync});
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tmds_encoder.sv ====
// TMDS 8b/10b encoder, transition minimizing, running disparity, control symbols
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder
  import holo_pkg::*;
(
  input  wire                clk_100_passthrough,
  input  wire                recent_reset,
  input  wire  [COLOR_W-1:0] data_i,
  input  var   tmds_ctrl_e   ctrl_i,
  input  wire                active_i,
  output logic [TMDS_W-1:0]  tmds_o
);

  logic [3:0]                    data_ones;
  logic                          use_xnor;
  logic [8:0]                    q_m;
  logic [3:0]                    qm_ones;
  logic signed [TMDS_DISP_W-1:0] qm_diff;
  logic signed [TMDS_DISP_W-1:0] disp_q;
  logic signed [TMDS_DISP_W-1:0] disp_next;
  logic [TMDS_W-1:0]             sym_next;
  logic [TMDS_W-1:0]             ctrl_sym;

  // popcount of a byte
  function automatic logic [3:0] ones8(input logic [7:0] v);
    logic [3:0] n;
    n = '0;
    for (int i = 0; i < 8; i++) begin
      n = n + {3'b000, v[i]};
    end
    return n;
  endfunction

  // stage 1, xor or xnor chain
  assign data_ones = ones8(data_i);
  assign use_xnor  = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data_i[0]);

  always_comb begin
    q_m[0] = data_i[0];
    for (int i = 1; i < 8; i++) begin
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_i[i]) : (q_m[i-1] ^ data_i[i]);
    end
    // bit 8 set means xor was used
    q_m[8] = ~use_xnor;
  end

  // ones minus zeros of the 8 data bits
  assign qm_ones = ones8(q_m[7:0]);
  assign qm_diff = $signed({1'b0, qm_ones, 1'b0}) - 6'sd8;

  // stage 2, dc balance
  always_comb begin
    if (disp_q == 0 || qm_diff == 0) begin
      // tie, let bit 8 pick the polarity
      sym_next  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      disp_next = q_m[8] ? disp_q + qm_diff : disp_q - qm_diff;
    end else if ((disp_q > 0 && qm_diff > 0) || (disp_q < 0 && qm_diff < 0)) begin
      // same sign as the running total, invert
      sym_next  = {1'b1, q_m[8], ~q_m[7:0]};
      disp_next = disp_q + (q_m[8] ? 6'sd2 : 6'sd0) - qm_diff;
    end else begin
      sym_next  = {1'b0, q_m[8], q_m[7:0]};
      disp_next = disp_q - (q_m[8] ? 6'sd0 : 6'sd2) + qm_diff;
    end
  end

  // blanking symbol
  always_comb begin
    case (ctrl_i)
      CTRL_NONE:  ctrl_sym = TMDS_CTRL_SYM0;
      CTRL_HSYNC: ctrl_sym = TMDS_CTRL_SYM1;
      CTRL_VSYNC: ctrl_sym = TMDS_CTRL_SYM2;
      CTRL_BOTH:  ctrl_sym = TMDS_CTRL_SYM3;
    endcase
  end

  // one cycle latency
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      tmds_o <= '0;
      disp_q <= '0;
    end else if (active_i) begin
      tmds_o <= sym_next;
      disp_q <= disp_next;
    end else begin
      // balance restarts after every blanking run
      tmds_o <= ctrl_sym;
      disp_q <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/video_out_top.sv ====
// display back end top level, timing generator, pixel fetch and three TMDS encoders
`timescale 1ns/1ps
`default_nettype none

module video_out_top
  import holo_pkg::*;
(
  input  wire                clk_100_passthrough,
  input  wire                recent_reset,
  input  wire                fb_tvalid_i,
  input  wire  [PIXEL_W-1:0] fb_tdata_i,
  input  wire                fb_tlast_i,
  output logic               fb_tready_o,
  output logic [TMDS_W-1:0]  tmds_red_o,
  output logic [TMDS_W-1:0]  tmds_green_o,
  output logic [TMDS_W-1:0]  tmds_blue_o
);

  // fetch to encoders, one cycle behind the counters
  logic [COLOR_W-1:0] red;
  logic [COLOR_W-1:0] green;
  logic [COLOR_W-1:0] blue;
  logic               active;
  tmds_ctrl_e         blue_ctrl;

  video_timing_if timing_bus ();

  video_timing_gen u_timing (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .timing_o            (timing_bus)
  );

  fb_pixel_fetch u_fetch (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .timing_i            (timing_bus),
    .fb_tvalid_i         (fb_tvalid_i),
    .fb_tdata_i          (fb_tdata_i),
    .fb_tlast_i          (fb_tlast_i),
    .fb_tready_o         (fb_tready_o),
    .red_o               (red),
    .green_o             (green),
    .blue_o              (blue),
    .active_o            (active),
    .blue_ctrl_o         (blue_ctrl)
  );

  // red and green send control 0 in blanking
  tmds_encoder u_tmds_red (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .data_i              (red),
    .ctrl_i              (CTRL_NONE),
    .active_i            (active),
    .tmds_o              (tmds_red_o)
  );

  tmds_encoder u_tmds_green (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .data_i              (green),
    .ctrl_i              (CTRL_NONE),
    .active_i            (active),
    .tmds_o              (tmds_green_o)
  );

  // syncs ride on blue
  tmds_encoder u_tmds_blue (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .data_i              (blue),
    .ctrl_i              (blue_ctrl),
    .active_i            (active),
    .tmds_o              (tmds_blue_o)
  );

endmodule

`default_nettype wire

// ==== verification/video_out_assertions.sv ====
// concurrent checks on the display top level, reset value, blanking symbols, ready window
`timescale 1ns/1ps
`default_nettype none

module video_out_assertions
  import holo_pkg::*;
(
  input wire                clk_100_passthrough,
  input wire                recent_reset,
  input wire                active_i,
  input wire [HCOUNT_W-1:0] hcount_i,
  input wire [VCOUNT_W-1:0] vcount_i,
  input wire                fb_tready_i,
  input wire [TMDS_W-1:0]   tmds_red_i,
  input wire [TMDS_W-1:0]   tmds_green_i,
  input wire [TMDS_W-1:0]   tmds_blue_i
);

  function automatic logic is_ctrl_symbol(input logic [TMDS_W-1:0] sym);
    return (sym == TMDS_CTRL_SYM0) || (sym == TMDS_CTRL_SYM1)
        || (sym == TMDS_CTRL_SYM2) || (sym == TMDS_CTRL_SYM3);
  endfunction

  // encoders cleared by reset
  assert property (@(posedge clk_100_passthrough) recent_reset
    |=> (tmds_red_i == '0) && (tmds_green_i == '0) && (tmds_blue_i == '0))
    else $error("tmds outputs not zero one cycle after reset");

  // encoder input inactive, next symbol from the control set
  assert property (@(posedge clk_100_passthrough) disable iff (recent_reset)
    !active_i |=> is_ctrl_symbol(tmds_red_i) && is_ctrl_symbol(tmds_green_i)
                  && is_ctrl_symbol(tmds_blue_i))
    else $error("blanking symbol is not a control symbol");

  assert property (@(posedge clk_100_passthrough)
    !((hcount_i < HCOUNT_W'(FB_HRES)) && (vcount_i < VCOUNT_W'(FB_VRES))) |-> !fb_tready_i)
    else $error("stream ready high outside the frame-buffer window");

endmodule

bind video_out_top video_out_assertions u_assertions (
  .clk_100_passthrough (clk_100_passthrough),
  .recent_reset        (recent_reset),
  .active_i            (active),
  .hcount_i            (timing_bus.hcount),
  .vcount_i            (timing_bus.vcount),
  .fb_tready_i         (fb_tready_o),
  .tmds_red_i          (tmds_red_o),
  .tmds_green_i        (tmds_green_o),
  .tmds_blue_i         (tmds_blue_o)
);

`default_nettype wire

// ==== verification/tb_video_out.sv ====
// testbench for the display back end, stimulus table, TMDS decode model, checks, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_video_out
  import holo_pkg::*;
();

  localparam int RUN_CYCLES     = 2 * H_TOTAL * V_TOTAL;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 1000;
  localparam int RESET_CYCLES   = 4;
  localparam int WINDOW_PIXELS  = FB_HRES * FB_VRES;
  localparam logic [31:0] RAND_SEED = 32'hdaba4e8c;
  // what the symbols of one cycle should be
  localparam logic [1:0] KIND_ZERO  = 2'd0;
  localparam logic [1:0] KIND_CTRL  = 2'd1;
  localparam logic [1:0] KIND_PIXEL = 2'd2;
  localparam logic [23:0] RGB_RED   = 24'hf80000;

  logic               clk_100_passthrough;
  logic               recent_reset;
  logic               fb_tvalid;
  logic [PIXEL_W-1:0] fb_tdata;
  logic               fb_tlast;
  logic               fb_tready;
  logic [TMDS_W-1:0]  tmds_red;
  logic [TMDS_W-1:0]  tmds_green;
  logic [TMDS_W-1:0]  tmds_blue;

  // {valid, tdata, red, green, blue}
  logic [40:0] stim_table [8];
  // {kind, vsync, hsync, rgb}, one per cycle, two cycles deep
  logic [27:0] expect_q [$];
  int          cycle_count;

  video_out_top u_dut (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .fb_tvalid_i         (fb_tvalid),
    .fb_tdata_i          (fb_tdata),
    .fb_tlast_i          (fb_tlast),
    .fb_tready_o         (fb_tready),
    .tmds_red_o          (tmds_red),
    .tmds_green_o        (tmds_green),
    .tmds_blue_o         (tmds_blue)
  );

  initial begin
    clk_100_passthrough = 1'b0;
    forever #5 clk_100_passthrough = ~clk_100_passthrough;
  end

  // fields to the top of each byte, zero fill
  function automatic logic [23:0] expand_rgb565(input logic [15:0] word);
    return {word[15:11], 3'b000, word[10:5], 2'b00, word[4:0], 3'b000};
  endfunction

  // undo the inversion, then the xor or xnor chain
  function automatic logic [7:0] decode_tmds(input logic [9:0] sym);
    logic [7:0] d;
    logic [7:0] data;
    d = sym[9] ? ~sym[7:0] : sym[7:0];
    data[0] = d[0];
    for (int i = 1; i < 8; i++) begin
      data[i] = sym[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return data;
  endfunction

  function automatic logic [9:0] ctrl_symbol(input logic [1:0] ctrl);
    logic [9:0] sym;
    case (ctrl)
      2'd0:    sym = 10'b1101010100;
      2'd1:    sym = 10'b0010101011;
      2'd2:    sym = 10'b0101010100;
      default: sym = 10'b1010101011;
    endcase
    return sym;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_symbols(input logic [27:0] exp_word);
    if (exp_word[27:26] == KIND_ZERO) begin
      check_value("tmds_red_o", 32'(tmds_red), 32'h0);
      check_value("tmds_green_o", 32'(tmds_green), 32'h0);
      check_value("tmds_blue_o", 32'(tmds_blue), 32'h0);
    end else if (exp_word[27:26] == KIND_CTRL) begin
      // red and green always control 0
      check_value("tmds_red_o", 32'(tmds_red), 32'(ctrl_symbol(2'd0)));
      check_value("tmds_green_o", 32'(tmds_green), 32'(ctrl_symbol(2'd0)));
      check_value("tmds_blue_o", 32'(tmds_blue), 32'(ctrl_symbol(exp_word[25:24])));
    end else begin
      check_value("tmds_red_o decoded", 32'(decode_tmds(tmds_red)), 32'(exp_word[23:16]));
      check_value("tmds_green_o decoded", 32'(decode_tmds(tmds_green)), 32'(exp_word[15:8]));
      check_value("tmds_blue_o decoded", 32'(decode_tmds(tmds_blue)), 32'(exp_word[7:0]));
    end
  endtask

  // drives the stream for one raster position and works out what it should produce
  task automatic drive_position(input int h, input int v, output logic [27:0] exp_word,
                                output logic ready_exp);
    logic       active;
    logic       hs;
    logic       vs;
    logic       in_win;
    logic       last;
    logic [3:0] cls;
    logic [40:0] row;
    logic [23:0] rgb;
    active = (h < H_ACTIVE) && (v < V_ACTIVE);
    hs     = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
    vs     = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
    in_win = (h < FB_HRES) && (v < FB_VRES);
    last   = in_win && (v * FB_HRES + h == WINDOW_PIXELS - 1);
    // eight table rows, then a random class
    cls    = 4'((v * FB_HRES + h) % 9);
    fb_tlast = last;
    if (in_win && cls < 4'd8) begin
      row       = stim_table[cls[2:0]];
      fb_tvalid = row[40];
      fb_tdata  = row[39:24];
      rgb       = row[23:0];
    end else begin
      // outside the window this word must be ignored
      fb_tvalid = 1'b1;
      fb_tdata  = 16'($urandom);
      rgb       = in_win ? expand_rgb565(fb_tdata) : RGB_RED;
    end
    ready_exp = last ? (active && (h == FB_HRES - 1) && (v == FB_VRES - 1)) : in_win;
    exp_word  = {(active ? KIND_PIXEL : KIND_CTRL), vs, hs, rgb};
  endtask

  initial begin : main_sequence
    logic [27:0] exp_word;
    logic        ready_exp;
    int          h;
    int          v;
    recent_reset = 1'b1;
    fb_tvalid    = 1'b0;
    fb_tdata     = '0;
    fb_tlast     = 1'b0;
    void'($urandom(RAND_SEED));
    stim_table[0] = {1'b1, 16'hffff, 8'hf8, 8'hfc, 8'hf8};
    stim_table[1] = {1'b1, 16'h0000, 8'h00, 8'h00, 8'h00};
    stim_table[2] = {1'b1, 16'hf800, 8'hf8, 8'h00, 8'h00};
    stim_table[3] = {1'b1, 16'h07e0, 8'h00, 8'hfc, 8'h00};
    stim_table[4] = {1'b1, 16'h001f, 8'h00, 8'h00, 8'hf8};
    stim_table[5] = {1'b0, 16'h1234, 8'hf8, 8'h00, 8'h00};
    stim_table[6] = {1'b1, 16'ha5a5, 8'ha0, 8'hb4, 8'h28};
    stim_table[7] = {1'b0, 16'h5a5a, 8'hf8, 8'h00, 8'h00};
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk_100_passthrough);
      check_symbols({KIND_ZERO, 26'h0});
    end
    @(negedge clk_100_passthrough);
    recent_reset = 1'b0;
    // still the reset value, then the fetch stage's reset state
    expect_q.push_back({KIND_ZERO, 26'h0});
    expect_q.push_back({KIND_CTRL, 26'h0});
    h = 0;
    v = 0;
    for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
      drive_position(h, v, exp_word, ready_exp);
      expect_q.push_back(exp_word);
      #1;
      check_value("fb_tready_o", 32'(fb_tready), 32'(ready_exp));
      check_symbols(expect_q.pop_front());
      if (h == H_TOTAL - 1) begin
        h = 0;
        v = (v == V_TOTAL - 1) ? 0 : v + 1;
      end else begin
        h = h + 1;
      end
      @(negedge clk_100_passthrough);
    end
    $display("TEST PASSED");
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_100_passthrough);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/holo_pkg.sv
verilog/video_timing_if.sv
verilog/video_timing_gen.sv
verilog/fb_pixel_fetch.sv
verilog/tmds_encoder.sv
verilog/video_out_top.sv
verification/video_out_assertions.sv
verification/tb_video_out.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the display back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_video_out -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_video_out)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
